// File: Makefile
TOP = tb_func_units

.PHONY: all build run lint clean

all: run

build:
	verilator --binary -j 0 -f project.f --top-module $(TOP) -o sim_$(TOP)

run: build
	./obj_dir/sim_$(TOP) > run.log 2>&1; cat run.log
	grep -q "Test passed" run.log

lint:
	verilator --lint-only -Wall -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir run.log

// File: project.f
+incdir+verilog
verilog/fu_pkg.sv
verilog/alu_unit.sv
verilog/load_store_unit.sv
verilog/writeback_arbiter.sv
verilog/func_units.sv
testbench/fu_checker.sv
testbench/tb_func_units.sv

// File: testbench/fu_checker.sv
`default_nettype none

`include "fu_cfg.svh"

module fu_checker
  import fu_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       alu_start,
  input  alu_issue_t alu_issue,
  input  logic       ls_start,
  input  ls_issue_t  ls_issue,
  input  logic       ls_ready,
  input  logic       rob_done,
  input  fu_result_t rob_result,
  output int         errors,
  output int         results
);

  // memory model, plus which words hold known data
  logic [`GPR_SIZE-1:0] mem_model [`DMEM_WORDS];
  logic                 written [`DMEM_WORDS];

  // one-deep alu expectation, valid the cycle after issue
  logic       alu_pend;
  fu_result_t alu_exp;

  // pending load/store expectation
  logic       ls_pend;
  int         ls_age;
  // result seen on the port with no alu result, so granted
  logic       ls_out;
  fu_result_t ls_exp;

  // odd codes invert the even code below them, al always true
  function automatic logic ref_cond(input logic [3:0] cond, input nzcv_t f);
    logic base;
    case (cond[3:1])
      3'd0: base = f.z;
      3'd1: base = f.c;
      3'd2: base = f.n;
      3'd3: base = f.v;
      3'd4: base = f.c & ~f.z;
      3'd5: base = (f.n == f.v);
      3'd6: base = (f.n == f.v) & ~f.z;
      default: base = 1'b1;
    endcase
    if (cond == 4'd14) begin
      return 1'b1;
    end
    return cond[0] ? ~base : base;
  endfunction

  function automatic logic [`GPR_SIZE-1:0] ref_value(input alu_issue_t is);
    logic take_a;
    take_a = ref_cond(is.cond, is.nzcv);
    case (is.op)
      ALU_OP_PLUS:  return is.val_a + is.val_b;
      ALU_OP_MINUS: return is.val_a - is.val_b;
      ALU_OP_OR:    return is.val_a | is.val_b;
      ALU_OP_ORN:   return is.val_a | ~is.val_b;
      ALU_OP_EOR:   return is.val_a ^ is.val_b;
      ALU_OP_AND:   return is.val_a & is.val_b;
      ALU_OP_CSEL:  return take_a ? is.val_a : is.val_b;
      ALU_OP_CSINC: return take_a ? is.val_a : is.val_b + 64'd1;
      ALU_OP_CSINV: return take_a ? is.val_a : ~is.val_b;
      ALU_OP_CSNEG: return take_a ? is.val_a : 64'd0 - is.val_b;
      default:      return '0;
    endcase
  endfunction

  function automatic nzcv_t ref_flags(input alu_issue_t is, input logic [`GPR_SIZE-1:0] res);
    nzcv_t              f;
    logic [`GPR_SIZE:0] sum;
    logic               sa;
    logic               sb;
    logic               sr;
    if (!is.set_nzcv) begin
      return is.nzcv;
    end
    sa  = is.val_a[`GPR_SIZE-1];
    sb  = is.val_b[`GPR_SIZE-1];
    sr  = res[`GPR_SIZE-1];
    f.n = sr;
    f.z = (res == '0);
    f.c = 1'b0;
    f.v = 1'b0;
    if (is.op == ALU_OP_PLUS) begin
      sum = {1'b0, is.val_a} + {1'b0, is.val_b};
      f.c = sum[`GPR_SIZE];
      f.v = (sa == sb) && (sr != sa);
    end else if (is.op == ALU_OP_MINUS) begin
      // c means no borrow
      f.c = (is.val_a >= is.val_b);
      f.v = (sa != sb) && (sr != sa);
    end
    return f;
  endfunction

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  // flags only matter for alu results
  task automatic check_result(input fu_result_t got, input fu_result_t exp, input logic flags);
    if (got.dst_rob_index !== exp.dst_rob_index || got.value !== exp.value ||
        got.set_nzcv !== exp.set_nzcv || (flags && got.nzcv !== exp.nzcv)) begin
      $display("FAILED rob_result got idx %h value %h set %h nzcv %h", got.dst_rob_index,
               got.value, got.set_nzcv, got.nzcv);
      $display("FAILED rob_result expected idx %h value %h set %h nzcv %h", exp.dst_rob_index,
               exp.value, exp.set_nzcv, exp.nzcv);
      errors++;
    end
  endtask

  // rising edge, inputs stable since the falling edge
  task automatic capture_inputs();
    logic [`DMEM_IDX_SIZE-1:0] idx;
    if (ls_out) begin
      ls_pend = 1'b0;
      ls_out  = 1'b0;
    end
    alu_pend = alu_start;
    if (alu_start) begin
      alu_exp.dst_rob_index = alu_issue.dst_rob_index;
      alu_exp.value         = ref_value(alu_issue);
      alu_exp.set_nzcv      = alu_issue.set_nzcv;
      alu_exp.nzcv          = ref_flags(alu_issue, alu_exp.value);
    end
    if (ls_pend) begin
      ls_age++;
    end
    if (ls_start) begin
      idx = ls_issue.addr[`DMEM_IDX_SIZE+`DMEM_OFS_SIZE-1:`DMEM_OFS_SIZE];
      if (ls_pend) begin
        $display("load/store request issued while the unit was still busy");
        errors++;
      end
      ls_pend = 1'b1;
      ls_age  = 0;
      ls_exp.dst_rob_index = ls_issue.dst_rob_index;
      ls_exp.set_nzcv      = 1'b0;
      ls_exp.nzcv          = '0;
      if (ls_issue.is_store) begin
        mem_model[idx] = ls_issue.store_val;
        written[idx]   = 1'b1;
        ls_exp.value   = '0;
      end else begin
        if (!written[idx]) begin
          $display("load issued from a memory word that was never written");
          errors++;
        end
        ls_exp.value = mem_model[idx];
      end
    end
  endtask

  // falling edge, outputs come from registers only
  task automatic compare_outputs();
    logic ls_due;
    ls_due = ls_pend && (ls_age >= 1);
    check_bit("rob_done", rob_done, alu_pend || ls_due);
    check_bit("ls_ready", ls_ready, !ls_pend);
    if (alu_pend) begin
      check_result(rob_result, alu_exp, 1'b1);
      results++;
    end else if (ls_due) begin
      check_result(rob_result, ls_exp, 1'b0);
      ls_out = 1'b1;
      results++;
    end
  endtask

  always @(posedge clk or negedge clk) begin
    if (!rst_n) begin
      alu_pend = 1'b0;
      ls_pend  = 1'b0;
      ls_out   = 1'b0;
      ls_age   = 0;
      for (int i = 0; i < `DMEM_WORDS; i++) begin
        written[i] = 1'b0;
      end
    end else if (clk) begin
      capture_inputs();
    end else begin
      compare_outputs();
    end
  end

endmodule

`default_nettype wire

// File: testbench/tb_func_units.sv
`default_nettype none

`include "fu_cfg.svh"

module tb_func_units
  import fu_pkg::*;
();

  logic       clk = 1'b0;
  logic       rst_n;
  logic       alu_start;
  alu_issue_t alu_issue;
  logic       ls_start;
  ls_issue_t  ls_issue;
  logic       ls_ready;
  logic       rob_done;
  fu_result_t rob_result;

  int errors;
  int results;

  // stimulus state
  logic [31:0]              lfsr;
  logic [`ROB_IDX_SIZE-1:0] rob_idx;
  int                       issued;
  logic                     timed_out;
  logic [63:0]              written_addr [8];

  always #4 clk = ~clk;

  func_units dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .alu_start (alu_start),
    .alu_issue (alu_issue),
    .ls_start  (ls_start),
    .ls_issue  (ls_issue),
    .ls_ready  (ls_ready),
    .rob_done  (rob_done),
    .rob_result(rob_result)
  );

  fu_checker chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .alu_start (alu_start),
    .alu_issue (alu_issue),
    .ls_start  (ls_start),
    .ls_issue  (ls_issue),
    .ls_ready  (ls_ready),
    .rob_done  (rob_done),
    .rob_result(rob_result),
    .errors    (errors),
    .results   (results)
  );

  // galois lfsr, right shifting
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  task automatic draw(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[62:0], lfsr[0]};
    end
  endtask

  // encoding 15 is not a listed code
  function automatic cond_t pick_cond(input logic [3:0] c);
    return (c == 4'hf) ? AL : cond_t'(c);
  endfunction

  // sets up one alu issue, caller advances the clock
  task automatic set_alu(input alu_op_t op, input cond_t cond, input logic setf);
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] f;
    logic [63:0] pick;
    draw(64, a);
    draw(64, b);
    draw(4, f);
    draw(2, pick);
    // equal operands now and then, for zero and borrow edges
    if (pick[1:0] == 2'd0) begin
      b = a;
    end
    alu_issue.op            = op;
    alu_issue.cond          = cond;
    alu_issue.val_a         = a;
    alu_issue.val_b         = b;
    alu_issue.dst_rob_index = rob_idx;
    alu_issue.set_nzcv      = setf;
    alu_issue.nzcv          = f[3:0];
    alu_start               = 1'b1;
    rob_idx++;
    issued++;
  endtask

  task automatic set_ls(input logic is_store, input logic [63:0] addr);
    logic [63:0] v;
    draw(64, v);
    ls_issue.is_store      = is_store;
    ls_issue.addr          = addr;
    ls_issue.store_val     = v;
    ls_issue.dst_rob_index = rob_idx;
    ls_start               = 1'b1;
    rob_idx++;
    issued++;
  endtask

  task automatic wait_ready();
    int cnt;
    cnt = 0;
    while (!ls_ready && cnt < 50) begin
      @(negedge clk);
      cnt++;
    end
    if (!ls_ready) begin
      $display("timeout while waiting for ls_ready to rise");
      timed_out = 1'b1;
    end
  endtask

  // same word, fresh byte offset
  function automatic logic [63:0] reoffset(input logic [63:0] addr, input logic [2:0] ofs);
    return {addr[63:3], ofs};
  endfunction

  initial begin
    logic [63:0] r;
    logic [63:0] o;
    int          cycles;
    int          len;
    alu_start = 1'b0;
    alu_issue = '0;
    ls_start  = 1'b0;
    ls_issue  = '0;
    rst_n     = 1'b0;
    lfsr      = 32'hbbff_1025;
    rob_idx   = '0;
    issued    = 0;
    timed_out = 1'b0;

    // reset for ten cycles
    cycles = 0;
    while (cycles < 10) begin
      @(posedge clk);
      cycles++;
    end
    @(negedge clk);
    rst_n = 1'b1;
    // idle, rob_done low and ls_ready high
    repeat (3) @(negedge clk);

    // every op with fresh flags, back to back
    for (int op = 0; op < 10; op++) begin
      for (int k = 0; k < 12; k++) begin
        draw(4, r);
        set_alu(alu_op_t'(op), pick_cond(r[3:0]), 1'b1);
        @(negedge clk);
      end
    end
    alu_start = 1'b0;
    @(negedge clk);

    // select family over every code, flags pass through
    for (int c = 0; c < 15; c++) begin
      for (int op = 6; op < 10; op++) begin
        set_alu(alu_op_t'(op), cond_t'(c), 1'b0);
        @(negedge clk);
      end
    end
    alu_start = 1'b0;
    @(negedge clk);

    // stores then loads of written words
    for (int i = 0; i < 8; i++) begin
      draw(5, r);
      draw(3, o);
      written_addr[i] = {56'd0, r[4:0], o[2:0]};
      wait_ready();
      if (!timed_out) begin
        set_ls(1'b1, written_addr[i]);
        @(negedge clk);
        ls_start = 1'b0;
      end
    end
    for (int i = 0; i < 8; i++) begin
      draw(3, r);
      draw(3, o);
      wait_ready();
      if (!timed_out) begin
        set_ls(1'b0, reoffset(written_addr[r[2:0]], o[2:0]));
        @(negedge clk);
        ls_start = 1'b0;
      end
    end

    // alu streams over a pending request, ls result must wait
    for (int t = 0; t < 8; t++) begin
      draw(3, r);
      draw(3, o);
      wait_ready();
      if (!timed_out) begin
        set_ls(t[0] == 1'b0, reoffset(written_addr[r[2:0]], o[2:0]));
        draw(4, r);
        set_alu(alu_op_t'(t % 10), pick_cond(r[3:0]), 1'b1);
        @(negedge clk);
        ls_start = 1'b0;
        draw(3, r);
        len = 2 + int'(r[2:0]);
        for (int j = 0; j < len; j++) begin
          draw(4, r);
          set_alu(alu_op_t'(j % 10), pick_cond(r[3:0]), r[0]);
          @(negedge clk);
        end
        alu_start = 1'b0;
      end
    end

    // drain until every issue has reported
    cycles = 0;
    while (results < issued && cycles < 100) begin
      @(negedge clk);
      cycles++;
    end
    if (results < issued) begin
      $display("timeout while waiting for outstanding results");
      timed_out = 1'b1;
    end
    repeat (2) @(negedge clk);
    if (results != issued) begin
      $display("result count does not match the number of issued operations");
    end

    $display("errors %0d, results %0d of %0d issued", errors, results, issued);
    if (errors == 0 && !timed_out && results == issued) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/alu_unit.sv
`default_nettype none

`include "fu_cfg.svh"

module alu_unit
  import fu_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       alu_start,
  input  alu_issue_t alu_issue,
  output logic       alu_done,
  output fu_result_t alu_result
);

  // registered issue, one cycle latency
  logic       start_q;
  alu_issue_t issue_q;

  // operand aliases
  logic [`GPR_SIZE-1:0] val_a;
  logic [`GPR_SIZE-1:0] val_b;

  // shared adder, subtract as a + ~b + 1
  logic                 is_minus;
  logic                 is_arith;
  logic [`GPR_SIZE-1:0] b_op;
  logic [`GPR_SIZE:0]   sum;
  logic                 add_c;
  logic                 add_v;

  logic                 cond_holds;
  logic [`GPR_SIZE-1:0] value;
  nzcv_t                flags;

  // aarch64 condition check against incoming flags
  function automatic logic eval_cond(input cond_t cond, input nzcv_t f);
    logic holds;
    case (cond)
      EQ: holds = f.z;
      NE: holds = !f.z;
      CS: holds = f.c;
      CC: holds = !f.c;
      MI: holds = f.n;
      PL: holds = !f.n;
      VS: holds = f.v;
      VC: holds = !f.v;
      HI: holds = f.c && !f.z;
      LS: holds = !(f.c && !f.z);
      GE: holds = (f.n == f.v);
      LT: holds = (f.n != f.v);
      GT: holds = !f.z && (f.n == f.v);
      LE: holds = f.z || (f.n != f.v);
      // al, and the unused encoding behaves the same
      default: holds = 1'b1;
    endcase
    return holds;
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start_q <= 1'b0;
      issue_q <= '0;
    end else begin
      start_q <= alu_start;
      issue_q <= alu_issue;
    end
  end

  assign val_a = issue_q.val_a;
  assign val_b = issue_q.val_b;

  assign is_minus = (issue_q.op == ALU_OP_MINUS);
  assign is_arith = (issue_q.op == ALU_OP_PLUS) || is_minus;
  assign b_op     = is_minus ? ~val_b : val_b;
  assign sum      = {1'b0, val_a} + {1'b0, b_op} + {{`GPR_SIZE{1'b0}}, is_minus};

  // carry out, for subtract this is "no borrow"
  assign add_c = sum[`GPR_SIZE];
  // same sign in, different sign out
  assign add_v = (val_a[`GPR_SIZE-1] == b_op[`GPR_SIZE-1]) &&
                 (sum[`GPR_SIZE-1] != val_a[`GPR_SIZE-1]);

  assign cond_holds = eval_cond(issue_q.cond, issue_q.nzcv);

  always_comb begin
    case (issue_q.op)
      ALU_OP_PLUS,
      ALU_OP_MINUS: value = sum[`GPR_SIZE-1:0];
      ALU_OP_OR:    value = val_a | val_b;
      ALU_OP_ORN:   value = val_a | ~val_b;
      ALU_OP_EOR:   value = val_a ^ val_b;
      ALU_OP_AND:   value = val_a & val_b;
      // select family, val_a when cond holds
      ALU_OP_CSEL:  value = cond_holds ? val_a : val_b;
      ALU_OP_CSINC: value = cond_holds ? val_a : val_b + 1;
      ALU_OP_CSINV: value = cond_holds ? val_a : ~val_b;
      ALU_OP_CSNEG: value = cond_holds ? val_a : ~val_b + 1;
      default:      value = '0;
    endcase
  end

  always_comb begin
    if (issue_q.set_nzcv) begin
      flags.n = value[`GPR_SIZE-1];
      flags.z = (value == '0);
      // logical and select ops clear c and v
      flags.c = is_arith && add_c;
      flags.v = is_arith && add_v;
    end else begin
      flags = issue_q.nzcv;
    end
  end

  assign alu_done = start_q;

  always_comb begin
    alu_result.dst_rob_index = issue_q.dst_rob_index;
    alu_result.value         = value;
    alu_result.set_nzcv      = issue_q.set_nzcv;
    alu_result.nzcv          = flags;
  end

endmodule

`default_nettype wire

// File: verilog/fu_cfg.svh
`ifndef FU_CFG_SVH
`define FU_CFG_SVH

// general purpose register width
`define GPR_SIZE 64

// rob entry index width, sixteen entries
`define ROB_IDX_SIZE 4

// data memory depth in 64-bit words
`define DMEM_WORDS 32

// word index width, taken from addr[7:3]
`define DMEM_IDX_SIZE 5

// byte offset bits below the word index, ignored
`define DMEM_OFS_SIZE 3

`endif

// File: verilog/fu_pkg.sv
`default_nettype none

`include "fu_cfg.svh"

package fu_pkg;

  // alu operation codes from the reservation stations
  typedef enum logic [3:0] {
    ALU_OP_PLUS,
    ALU_OP_MINUS,
    ALU_OP_OR,
    ALU_OP_ORN,
    ALU_OP_EOR,
    ALU_OP_AND,
    ALU_OP_CSEL,
    ALU_OP_CSINC,
    ALU_OP_CSINV,
    ALU_OP_CSNEG
  } alu_op_t;

  // aarch64 condition field encoding
  typedef enum logic [3:0] {
    EQ = 4'd0,
    NE = 4'd1,
    CS = 4'd2,
    CC = 4'd3,
    MI = 4'd4,
    PL = 4'd5,
    VS = 4'd6,
    VC = 4'd7,
    HI = 4'd8,
    LS = 4'd9,
    GE = 4'd10,
    LT = 4'd11,
    GT = 4'd12,
    LE = 4'd13,
    AL = 4'd14
  } cond_t;

  // condition flags, n in the top bit
  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } nzcv_t;

  // one alu operation as issued
  typedef struct packed {
    alu_op_t                  op;
    cond_t                    cond;
    logic [`GPR_SIZE-1:0]     val_a;
    logic [`GPR_SIZE-1:0]     val_b;
    logic [`ROB_IDX_SIZE-1:0] dst_rob_index;
    logic                     set_nzcv;
    // flags from before the operation
    nzcv_t                    nzcv;
  } alu_issue_t;

  // one load or store request
  typedef struct packed {
    logic                     is_store;
    logic [63:0]              addr;
    logic [`GPR_SIZE-1:0]     store_val;
    logic [`ROB_IDX_SIZE-1:0] dst_rob_index;
  } ls_issue_t;

  // completed result towards the rob
  typedef struct packed {
    logic [`ROB_IDX_SIZE-1:0] dst_rob_index;
    logic [`GPR_SIZE-1:0]     value;
    logic                     set_nzcv;
    nzcv_t                    nzcv;
  } fu_result_t;

endpackage

`default_nettype wire

// File: verilog/func_units.sv
`default_nettype none

module func_units
  import fu_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  // from the reservation stations
  input  logic       alu_start,
  input  alu_issue_t alu_issue,
  input  logic       ls_start,
  input  ls_issue_t  ls_issue,
  // back to the reservation stations
  output logic       ls_ready,
  // to the rob
  output logic       rob_done,
  output fu_result_t rob_result
);

  // unit results into the arbiter
  logic       alu_done;
  fu_result_t alu_result;
  logic       ls_done;
  fu_result_t ls_result;
  // arbiter grant back to the load/store unit
  logic       ls_grant;

  alu_unit u_alu (
    .clk       (clk),
    .rst_n     (rst_n),
    .alu_start (alu_start),
    .alu_issue (alu_issue),
    .alu_done  (alu_done),
    .alu_result(alu_result)
  );

  load_store_unit u_ls (
    .clk      (clk),
    .rst_n    (rst_n),
    .ls_start (ls_start),
    .ls_issue (ls_issue),
    .ls_grant (ls_grant),
    .ls_ready (ls_ready),
    .ls_done  (ls_done),
    .ls_result(ls_result)
  );

  writeback_arbiter u_arb (
    .alu_done  (alu_done),
    .alu_result(alu_result),
    .ls_done   (ls_done),
    .ls_result (ls_result),
    .ls_grant  (ls_grant),
    .rob_done  (rob_done),
    .rob_result(rob_result)
  );

endmodule

`default_nettype wire

// File: verilog/load_store_unit.sv
`default_nettype none

`include "fu_cfg.svh"

module load_store_unit
  import fu_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       ls_start,
  input  ls_issue_t  ls_issue,
  input  logic       ls_grant,
  output logic       ls_ready,
  output logic       ls_done,
  output fu_result_t ls_result
);

  // idle takes a request, access touches memory, hold waits for grant
  typedef enum logic [1:0] {
    LS_IDLE,
    LS_ACCESS,
    LS_HOLD
  } ls_state_t;

  ls_state_t state_q;
  ls_state_t state_d;

  // single request slot
  ls_issue_t req_q;

  // word-wide data memory
  logic [`GPR_SIZE-1:0] mem [`DMEM_WORDS];
  logic [`DMEM_IDX_SIZE-1:0] word_idx;

  // held result value
  logic [`GPR_SIZE-1:0] value_q;

  logic take_req;
  logic do_access;

  // low byte offset dropped, aligned words only
  assign word_idx = req_q.addr[`DMEM_IDX_SIZE+`DMEM_OFS_SIZE-1:`DMEM_OFS_SIZE];

  assign take_req  = ls_start && (state_q == LS_IDLE);
  assign do_access = (state_q == LS_ACCESS);

  always_comb begin
    state_d = state_q;
    case (state_q)
      LS_IDLE: begin
        if (ls_start) begin
          state_d = LS_ACCESS;
        end
      end
      LS_ACCESS: begin
        state_d = LS_HOLD;
      end
      LS_HOLD: begin
        // stays here while the alu owns the rob port
        if (ls_grant) begin
          state_d = LS_IDLE;
        end
      end
      default: begin
        state_d = LS_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= LS_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (take_req) begin
      req_q <= ls_issue;
    end
  end

  // store write and load capture, both one edge after the request
  always_ff @(posedge clk) begin
    if (do_access) begin
      if (req_q.is_store) begin
        mem[word_idx] <= req_q.store_val;
        value_q       <= '0;
      end else begin
        value_q <= mem[word_idx];
      end
    end
  end

  assign ls_ready = (state_q == LS_IDLE);
  assign ls_done  = (state_q == LS_HOLD);

  // loads and stores never touch the flags
  always_comb begin
    ls_result.dst_rob_index = req_q.dst_rob_index;
    ls_result.value         = value_q;
    ls_result.set_nzcv      = 1'b0;
    ls_result.nzcv          = '0;
  end

endmodule

`default_nettype wire

// File: verilog/writeback_arbiter.sv
`default_nettype none

module writeback_arbiter
  import fu_pkg::*;
(
  // alu side, one result per cycle, never stalled
  input  logic       alu_done,
  input  fu_result_t alu_result,
  // load/store side, held until granted
  input  logic       ls_done,
  input  fu_result_t ls_result,
  output logic       ls_grant,
  // single rob write port
  output logic       rob_done,
  output fu_result_t rob_result
);

  // fixed priority, alu first
  logic alu_sel;

  assign alu_sel = alu_done;

  // ls result only goes out in a cycle without an alu result
  assign ls_grant = ls_done && !alu_sel;

  // either unit finishing fills the port
  assign rob_done = alu_done || ls_done;

  always_comb begin
    if (alu_sel) begin
      rob_result = alu_result;
    end else begin
      // also the idle case, ignored while rob_done is low
      rob_result = ls_result;
    end
  end

endmodule

`default_nettype wire
